//--- rx_meta_pkg.sv
`default_nettype none

package rx_meta_pkg;

// Queue ids and packet sizes
localparam int FLOW_IDX_WIDTH = 4;
localparam int MAX_NB_FLOWS = 12;
localparam int PKT_SIZE_WIDTH = 16;

// Head update FIFO and output FIFO sizing
localparam int HEAD_UPD_QUEUE_LEN = 16;
localparam int HEAD_UPD_MARGIN = 4;
localparam int HEAD_UPD_OCC_WIDTH = $clog2(HEAD_UPD_QUEUE_LEN + 1);
localparam int IN_QUEUE_LEN = 8;
localparam int IN_QUEUE_ALMOST_FULL = 4;
localparam int IN_QUEUE_OCC_WIDTH = $clog2(IN_QUEUE_LEN + 1);

// Register bus
localparam int WB_ADDR_WIDTH = 8;
localparam int WB_DATA_WIDTH = 32;
localparam int WB_SEL_WIDTH = WB_DATA_WIDTH / 8;

localparam logic [WB_ADDR_WIDTH-1:0] REG_CONTROL = 8'h00;
localparam logic [WB_ADDR_WIDTH-1:0] REG_IGNORED_HEAD_CNT = 8'h01;
localparam logic [WB_ADDR_WIDTH-1:0] REG_HEAD_UPD_CNT = 8'h02;
localparam logic [WB_ADDR_WIDTH-1:0] REG_META_IN_CNT = 8'h03;
// Low address bits inside this region select the queue
localparam logic [WB_ADDR_WIDTH-1:0] HEAD_REGION_BASE = 8'h80;

localparam int CTRL_DISABLE_BIT = 0;
localparam int CTRL_SW_RESET_BIT = 1;

// Statistics
localparam int STAT_WIDTH = 32;
localparam int NB_STATS = 3;

typedef struct packed {
    logic [FLOW_IDX_WIDTH-1:0] pkt_queue_id;
    logic [PKT_SIZE_WIDTH-1:0] size;
} pkt_meta_t;

typedef struct packed {
    logic [FLOW_IDX_WIDTH-1:0] pkt_queue_id;
    logic [PKT_SIZE_WIDTH-1:0] size;
    logic                      descriptor_only;
    logic                      needs_dsc;
} queue_meta_t;

typedef struct packed {
    logic                     cyc;
    logic                     stb;
    logic                     we;
    logic [WB_ADDR_WIDTH-1:0] adr;
    logic [WB_SEL_WIDTH-1:0]  sel;
    logic [WB_DATA_WIDTH-1:0] dat_w;
} wb_req_t;

typedef struct packed {
    logic                     ack;
    logic [WB_DATA_WIDTH-1:0] dat_r;
} wb_rsp_t;

typedef struct packed {
    logic [STAT_WIDTH-1:0] ignored_head_cnt;
    logic [STAT_WIDTH-1:0] head_upd_cnt;
    logic [STAT_WIDTH-1:0] meta_in_cnt;
} rx_stats_t;

endpackage

`default_nettype wire

//--- sync_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic                       pcie_clk,
    input  logic                       pcie_reset_n,
    input  logic [WIDTH-1:0]           in_data,
    input  logic                       in_valid,
    output logic                       in_ready,
    output logic [WIDTH-1:0]           out_data,
    output logic                       out_valid,
    input  logic                       out_ready,
    output logic [$clog2(DEPTH+1)-1:0] occup
);

localparam int ADDR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int CNT_WIDTH = $clog2(DEPTH + 1);

logic [WIDTH-1:0]      mem [DEPTH];
logic [ADDR_WIDTH-1:0] wr_ptr;
logic [ADDR_WIDTH-1:0] rd_ptr;
logic [CNT_WIDTH-1:0]  count;
logic                  push;
logic                  pop;

assign in_ready = int'(count) != DEPTH;
assign out_valid = count != '0;
assign push = in_valid & in_ready;
assign pop = out_valid & out_ready;
assign occup = count;

// The oldest entry is always on the output
assign out_data = mem[rd_ptr];

always_ff @(posedge pcie_clk) begin
    if (push) begin
        mem[wr_ptr] <= in_data;
    end
end

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count <= '0;
    end else begin
        if (push) begin
            wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
        end
        if (pop) begin
            rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
        end
        // Simultaneous push and pop leave the count unchanged
        if (push && !pop) begin
            count <= count + 1'b1;
        end else if (pop && !push) begin
            count <= count - 1'b1;
        end
    end
end

endmodule

`default_nettype wire

//--- mmio_regs.sv
`timescale 1ns/100ps
`default_nettype none

module mmio_regs (
    input  logic                                   pcie_clk,
    input  logic                                   pcie_reset_n,
    input  var rx_meta_pkg::wb_req_t               wb_req,
    output rx_meta_pkg::wb_rsp_t                   wb_rsp,
    input  var rx_meta_pkg::rx_stats_t             stats,
    output logic                                   disable_pcie,
    output logic                                   sw_reset,
    output logic                                   head_upd_valid,
    output logic [rx_meta_pkg::FLOW_IDX_WIDTH-1:0] head_upd_queue
);

import rx_meta_pkg::*;

logic [WB_DATA_WIDTH-1:0]  control_reg;
logic [WB_DATA_WIDTH-1:0]  rd_mux;
logic [WB_DATA_WIDTH-1:0]  rd_data;
logic [FLOW_IDX_WIDTH-1:0] queue_id;
logic                      ack;
logic                      access;
logic                      in_head_region;
logic                      head_write;
logic                      sw_reset_r1;

// Only the first cycle of a request counts. The cycle carrying ack ends it
assign access = wb_req.cyc & wb_req.stb & !ack;

assign queue_id = wb_req.adr[FLOW_IDX_WIDTH-1:0];
assign in_head_region = wb_req.adr[WB_ADDR_WIDTH-1:FLOW_IDX_WIDTH] ==
    HEAD_REGION_BASE[WB_ADDR_WIDTH-1:FLOW_IDX_WIDTH];

// Partial writes and out of range queues are acknowledged and dropped
assign head_write = access & wb_req.we & in_head_region &
    (wb_req.sel == '1) & (int'(queue_id) < MAX_NB_FLOWS);

always_comb begin
    case (wb_req.adr)
        REG_CONTROL:          rd_mux = control_reg;
        REG_IGNORED_HEAD_CNT: rd_mux = stats.ignored_head_cnt;
        REG_HEAD_UPD_CNT:     rd_mux = stats.head_upd_cnt;
        REG_META_IN_CNT:      rd_mux = stats.meta_in_cnt;
        default:              rd_mux = '0;
    endcase
end

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        ack <= 1'b0;
        head_upd_valid <= 1'b0;
        control_reg <= '0;
    end else begin
        ack <= access;
        head_upd_valid <= head_write;
        if (access && wb_req.we && wb_req.adr == REG_CONTROL) begin
            for (int i = 0; i < WB_SEL_WIDTH; i++) begin
                if (wb_req.sel[i]) begin
                    control_reg[8*i +: 8] <= wb_req.dat_w[8*i +: 8];
                end
            end
        end
    end
end

always_ff @(posedge pcie_clk) begin
    if (access) begin
        rd_data <= wb_req.we ? '0 : rd_mux;
    end
    if (head_write) begin
        head_upd_queue <= queue_id;
    end
end

// Software reset goes through two flops before it reaches the counters
always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        sw_reset_r1 <= 1'b0;
        sw_reset <= 1'b0;
    end else begin
        sw_reset_r1 <= control_reg[CTRL_SW_RESET_BIT];
        sw_reset <= sw_reset_r1;
    end
end

assign disable_pcie = control_reg[CTRL_DISABLE_BIT];
assign wb_rsp.ack = ack;
assign wb_rsp.dat_r = rd_data;

endmodule

`default_nettype wire

//--- rx_stats_counters.sv
`timescale 1ns/100ps
`default_nettype none

module rx_stats_counters (
    input  logic                   pcie_clk,
    input  logic                   pcie_reset_n,
    input  logic                   sw_reset,
    input  logic                   head_ignored,
    input  logic                   head_served,
    input  logic                   meta_accepted,
    output rx_meta_pkg::rx_stats_t stats
);

import rx_meta_pkg::*;

logic [NB_STATS-1:0]   events;
logic [STAT_WIDTH-1:0] counters [NB_STATS];

assign events = {meta_accepted, head_served, head_ignored};

// Counters wrap silently at the top of their range
always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n || sw_reset) begin
        for (int i = 0; i < NB_STATS; i++) begin
            counters[i] <= '0;
        end
    end else begin
        for (int i = 0; i < NB_STATS; i++) begin
            if (events[i]) begin
                counters[i] <= counters[i] + 1'b1;
            end
        end
    end
end

assign stats.ignored_head_cnt = counters[0];
assign stats.head_upd_cnt = counters[1];
assign stats.meta_in_cnt = counters[2];

endmodule

`default_nettype wire

//--- rx_meta_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module rx_meta_arbiter (
    input  logic                                       pcie_clk,
    input  logic                                       pcie_reset_n,
    input  logic                                       head_upd_valid,
    input  logic [rx_meta_pkg::FLOW_IDX_WIDTH-1:0]     head_upd_queue,
    input  var rx_meta_pkg::pkt_meta_t                 meta_in,
    input  logic                                       meta_in_valid,
    output logic                                       meta_in_ready,
    output rx_meta_pkg::queue_meta_t                   out_meta,
    output logic                                       out_meta_valid,
    input  logic [rx_meta_pkg::IN_QUEUE_OCC_WIDTH-1:0] out_occup,
    output logic                                       head_ignored,
    output logic                                       head_served,
    output logic                                       meta_accepted
);

import rx_meta_pkg::*;

logic [HEAD_UPD_OCC_WIDTH-1:0] head_occup;
logic [FLOW_IDX_WIDTH-1:0]     head_in_data;
logic                          head_in_valid;
logic [FLOW_IDX_WIDTH-1:0]     head_out_data;
logic                          head_out_valid;
logic                          head_out_ready;
logic                          head_almost_full;
logic                          out_almost_full;
logic                          same_queue;
logic                          merge_head_pkt;
logic                          head_fire;
logic                          meta_fire;

// The margin covers the push that is still in its register
assign head_almost_full = int'(head_occup) > HEAD_UPD_QUEUE_LEN - HEAD_UPD_MARGIN;
assign out_almost_full = int'(out_occup) > IN_QUEUE_ALMOST_FULL;

assign head_ignored = head_upd_valid & head_almost_full;

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        head_in_valid <= 1'b0;
    end else begin
        head_in_valid <= head_upd_valid & !head_almost_full;
    end
end

always_ff @(posedge pcie_clk) begin
    if (head_upd_valid) begin
        head_in_data <= head_upd_queue;
    end
end

sync_fifo #(
    .WIDTH (FLOW_IDX_WIDTH),
    .DEPTH (HEAD_UPD_QUEUE_LEN)
) head_upd_fifo_inst (
    .pcie_clk     (pcie_clk),
    .pcie_reset_n (pcie_reset_n),
    .in_data      (head_in_data),
    .in_valid     (head_in_valid),
    .in_ready     (),
    .out_data     (head_out_data),
    .out_valid    (head_out_valid),
    .out_ready    (head_out_ready),
    .occup        (head_occup)
);

assign same_queue = head_out_data == meta_in.pkt_queue_id;

// Head updates win over packets. A packet for the same queue rides along
always_comb begin
    head_out_ready = 1'b0;
    meta_in_ready = 1'b0;
    if (!out_almost_full) begin
        head_out_ready = 1'b1;
        meta_in_ready = head_out_valid ? same_queue : 1'b1;
    end
end

assign head_fire = head_out_valid & head_out_ready;
assign meta_fire = meta_in_valid & meta_in_ready;
assign merge_head_pkt = head_fire & meta_fire;

assign head_served = head_fire;
assign meta_accepted = meta_fire;

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        out_meta_valid <= 1'b0;
    end else begin
        out_meta_valid <= head_fire | meta_fire;
    end
end

// A merged entry is the packet with needs_dsc set
always_ff @(posedge pcie_clk) begin
    if (meta_fire) begin
        out_meta.pkt_queue_id <= meta_in.pkt_queue_id;
        out_meta.size <= meta_in.size;
        out_meta.descriptor_only <= 1'b0;
        out_meta.needs_dsc <= merge_head_pkt;
    end else if (head_fire) begin
        out_meta.pkt_queue_id <= head_out_data;
        out_meta.size <= '0;
        out_meta.descriptor_only <= 1'b1;
        out_meta.needs_dsc <= 1'b0;
    end
end

endmodule

`default_nettype wire

//--- rx_meta_top.sv
`timescale 1ns/100ps
`default_nettype none

module rx_meta_top (
    input  logic                     pcie_clk,
    input  logic                     pcie_reset_n,
    input  var rx_meta_pkg::wb_req_t wb_req,
    output rx_meta_pkg::wb_rsp_t     wb_rsp,
    input  var rx_meta_pkg::pkt_meta_t meta_in,
    input  logic                     meta_in_valid,
    output logic                     meta_in_ready,
    output rx_meta_pkg::queue_meta_t meta_out,
    output logic                     meta_out_valid,
    input  logic                     meta_out_ready,
    output logic                     disable_pcie
);

import rx_meta_pkg::*;

rx_stats_t                     stats;
logic                          sw_reset;
logic                          head_upd_valid;
logic [FLOW_IDX_WIDTH-1:0]     head_upd_queue;
queue_meta_t                   out_meta;
logic                          out_meta_valid;
logic [IN_QUEUE_OCC_WIDTH-1:0] out_occup;
logic                          head_ignored;
logic                          head_served;
logic                          meta_accepted;

mmio_regs mmio_regs_inst (
    .pcie_clk       (pcie_clk),
    .pcie_reset_n   (pcie_reset_n),
    .wb_req         (wb_req),
    .wb_rsp         (wb_rsp),
    .stats          (stats),
    .disable_pcie   (disable_pcie),
    .sw_reset       (sw_reset),
    .head_upd_valid (head_upd_valid),
    .head_upd_queue (head_upd_queue)
);

rx_stats_counters rx_stats_counters_inst (
    .pcie_clk      (pcie_clk),
    .pcie_reset_n  (pcie_reset_n),
    .sw_reset      (sw_reset),
    .head_ignored  (head_ignored),
    .head_served   (head_served),
    .meta_accepted (meta_accepted),
    .stats         (stats)
);

rx_meta_arbiter rx_meta_arbiter_inst (
    .pcie_clk       (pcie_clk),
    .pcie_reset_n   (pcie_reset_n),
    .head_upd_valid (head_upd_valid),
    .head_upd_queue (head_upd_queue),
    .meta_in        (meta_in),
    .meta_in_valid  (meta_in_valid),
    .meta_in_ready  (meta_in_ready),
    .out_meta       (out_meta),
    .out_meta_valid (out_meta_valid),
    .out_occup      (out_occup),
    .head_ignored   (head_ignored),
    .head_served    (head_served),
    .meta_accepted  (meta_accepted)
);

// The arbiter stalls early enough that this queue never refuses a push
sync_fifo #(
    .WIDTH ($bits(queue_meta_t)),
    .DEPTH (IN_QUEUE_LEN)
) in_queue_inst (
    .pcie_clk     (pcie_clk),
    .pcie_reset_n (pcie_reset_n),
    .in_data      (out_meta),
    .in_valid     (out_meta_valid),
    .in_ready     (),
    .out_data     (meta_out),
    .out_valid    (meta_out_valid),
    .out_ready    (meta_out_ready),
    .occup        (out_occup)
);

endmodule

`default_nettype wire

//--- tb_rx_meta_tests.svh
task automatic load_table;
    // Control register drives disable and reads back
    step_write("control", REG_CONTROL, 4'hf, 32'h0000_0501);
    step("control", OP_DISABLE, 32'h1);
    step_read("control", REG_CONTROL, 32'h0000_0501);
    step_write("control", REG_CONTROL, 4'hf, 32'h0);
    step("control", OP_DISABLE, 32'h0);
    step_read("control", REG_CONTROL, 32'h0);

    step_packet("single", 4'd2, RAND_SIZE);
    step_expect("single", 4'd2, RAND_SIZE, 1'b0, 1'b0);
    step_packet("single", 4'd11, 32'h0040);
    step_expect("single", 4'd11, 32'h0040, 1'b0, 1'b0);
    step("single", OP_DRAIN, 32'h0);
    step_write("single", HEAD_REGION_BASE + 8'd7, 4'hf, 32'h0000_1234);
    step_expect("single", 4'd7, 32'h0, 1'b1, 1'b0);
    step("single", OP_DRAIN, 32'h0);
    // Partial sel and an out of range queue leave no trace
    step_write("single", HEAD_REGION_BASE + 8'd7, 4'h3, 32'h0000_1234);
    step_write("single", HEAD_REGION_BASE + 8'd13, 4'hf, 32'h0000_1234);
    step("single", OP_DRAIN, 32'h0);

    // Five fillers push the output queue past its threshold so the arbiter stalls
    step("merge", OP_HOLD, 32'h0);
    for (int i = 0; i < 5; i++) begin
        step_packet("merge", 4'(i), 32'(100 + i));
    end
    step("merge", OP_SETTLE, 32'h0);
    step_write("merge", HEAD_REGION_BASE + 8'd3, 4'hf, 32'h0);
    step_packet("merge", 4'd3, 32'h0123);
    step("merge", OP_RELEASE, 32'h0);
    for (int i = 0; i < 5; i++) begin
        step_expect("merge", 4'(i), 32'(100 + i), 1'b0, 1'b0);
    end
    step_expect("merge", 4'd3, 32'h0123, 1'b0, 1'b1);
    step("merge", OP_DRAIN, 32'h0);

    step("order", OP_HOLD, 32'h0);
    for (int i = 0; i < 5; i++) begin
        step_packet("order", 4'(i), 32'(200 + i));
    end
    step("order", OP_SETTLE, 32'h0);
    step_write("order", HEAD_REGION_BASE + 8'd3, 4'hf, 32'h0);
    step_packet("order", 4'd5, 32'h0077);
    step("order", OP_RELEASE, 32'h0);
    for (int i = 0; i < 5; i++) begin
        step_expect("order", 4'(i), 32'(200 + i), 1'b0, 1'b0);
    end
    step_expect("order", 4'd3, 32'h0, 1'b1, 1'b0);
    step_expect("order", 4'd5, 32'h0077, 1'b0, 1'b0);
    step("order", OP_DRAIN, 32'h0);

    step_write("overflow", REG_CONTROL, 4'hf, 32'h2);
    step_write("overflow", REG_CONTROL, 4'hf, 32'h0);
    step("overflow", OP_HOLD, 32'h0);
    for (int i = 0; i < 30; i++) begin
        step_write("overflow", HEAD_REGION_BASE + 8'(i % MAX_NB_FLOWS), 4'hf, 32'(i));
    end
    step("overflow", OP_RELEASE, 32'h0);
    step("overflow", OP_BALANCE, 32'd30);

    // One packet first so every counter holds a nonzero value before the reset
    step_packet("sw_reset", 4'd6, 32'h0030);
    step_expect("sw_reset", 4'd6, 32'h0030, 1'b0, 1'b0);
    step("sw_reset", OP_DRAIN, 32'h0);
    step_write("sw_reset", REG_CONTROL, 4'hf, 32'h2);
    step_write("sw_reset", REG_CONTROL, 4'hf, 32'h0);
    step_read("sw_reset", REG_IGNORED_HEAD_CNT, 32'h0);
    step_read("sw_reset", REG_HEAD_UPD_CNT, 32'h0);
    step_read("sw_reset", REG_META_IN_CNT, 32'h0);
    step_packet("sw_reset", 4'd1, 32'h0005);
    step_packet("sw_reset", 4'd4, 32'h0009);
    step_expect("sw_reset", 4'd1, 32'h0005, 1'b0, 1'b0);
    step_expect("sw_reset", 4'd4, 32'h0009, 1'b0, 1'b0);
    step("sw_reset", OP_DRAIN, 32'h0);
    step_read("sw_reset", REG_META_IN_CNT, 32'h2);
endtask

//--- tb_rx_meta_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rx_meta_top;

import rx_meta_pkg::*;

localparam int CLK_PERIOD = 100;
localparam int ROW_BOUND_CYCLES = 400;
localparam int ACK_TIMEOUT = 20;
localparam int DRAIN_TIMEOUT = 200;
localparam int IDLE_CYCLES = 8;
localparam logic [31:0] RAND_SIZE = 32'h8000_0000;

localparam int OP_WRITE = 0;
localparam int OP_READ = 1;
localparam int OP_PKT = 2;
localparam int OP_EXPECT = 3;
localparam int OP_HOLD = 4;
localparam int OP_RELEASE = 5;
localparam int OP_DRAIN = 6;
localparam int OP_DISABLE = 7;
localparam int OP_SETTLE = 8;
localparam int OP_BALANCE = 9;

logic        pcie_clk = 1'b0;
logic        pcie_reset_n = 1'b0;
wb_req_t     wb_req = '0;
wb_rsp_t     wb_rsp;
pkt_meta_t   meta_in = '0;
logic        meta_in_valid = 1'b0;
logic        meta_in_ready;
queue_meta_t meta_out;
logic        meta_out_valid;
logic        meta_out_ready = 1'b1;
logic        disable_pcie;

string       name_q[$];
int          op_q[$];
logic [7:0]  adr_q[$];
logic [3:0]  sel_q[$];
logic [31:0] data_q[$];

pkt_meta_t   pkt_q[$];
queue_meta_t exp_q[$];
queue_meta_t sb_q[$];
bit          in_fire = 1'b0;
int          seed = 56;
logic [15:0] last_rand_size = '0;
int          rows = 0;
int          errors = 0;
int          test_errors = 0;
int          tests_passed = 0;
int          tests_failed = 0;

always #(CLK_PERIOD / 2) pcie_clk = ~pcie_clk;

rx_meta_top rx_meta_top_inst (
    .pcie_clk       (pcie_clk),
    .pcie_reset_n   (pcie_reset_n),
    .wb_req         (wb_req),
    .wb_rsp         (wb_rsp),
    .meta_in        (meta_in),
    .meta_in_valid  (meta_in_valid),
    .meta_in_ready  (meta_in_ready),
    .meta_out       (meta_out),
    .meta_out_valid (meta_out_valid),
    .meta_out_ready (meta_out_ready),
    .disable_pcie   (disable_pcie)
);

// Handshakes are sampled in the middle of the cycle
always @(negedge pcie_clk) begin
    in_fire = meta_in_valid && meta_in_ready;
    if (meta_out_valid && meta_out_ready) begin
        sb_q.push_back(meta_out);
    end
end

// Packet driver presents the oldest queued packet until it is taken
always @(posedge pcie_clk) begin
    #1;
    if (in_fire) begin
        void'(pkt_q.pop_front());
    end
    if (pkt_q.size() != 0) begin
        meta_in = pkt_q[0];
        meta_in_valid = 1'b1;
    end else begin
        meta_in_valid = 1'b0;
    end
end

task automatic add_step(string name, int op, logic [7:0] adr, logic [3:0] sel,
                        logic [31:0] data);
    name_q.push_back(name);
    op_q.push_back(op);
    adr_q.push_back(adr);
    sel_q.push_back(sel);
    data_q.push_back(data);
endtask

task automatic step_write(string name, logic [7:0] adr, logic [3:0] sel, logic [31:0] data);
    add_step(name, OP_WRITE, adr, sel, data);
endtask

task automatic step_read(string name, logic [7:0] adr, logic [31:0] expected);
    add_step(name, OP_READ, adr, 4'hf, expected);
endtask

task automatic step_packet(string name, logic [3:0] queue, logic [31:0] size);
    add_step(name, OP_PKT, {4'h0, queue}, 4'h0, size);
endtask

task automatic step_expect(string name, logic [3:0] queue, logic [31:0] size,
                           logic dsc_only, logic needs_dsc);
    add_step(name, OP_EXPECT, {4'h0, queue}, 4'h0,
             {size[31], 13'h0, dsc_only, needs_dsc, size[15:0]});
endtask

task automatic step(string name, int op, logic [31:0] data);
    add_step(name, op, 8'h00, 4'h0, data);
endtask

`include "tb_rx_meta_tests.svh"

task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    assert (expected == actual) else begin
        $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        test_errors++;
    end
endtask

task automatic bus_access(string name, logic we, logic [7:0] adr, logic [3:0] sel,
                          logic [31:0] data, output logic [31:0] rdata);
    int  n;
    bit  acked;
    n = 0;
    acked = 1'b0;
    @(posedge pcie_clk);
    #1;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we = we;
    wb_req.adr = adr;
    wb_req.sel = sel;
    wb_req.dat_w = data;
    while (!acked && n < ACK_TIMEOUT) begin
        @(negedge pcie_clk);
        acked = wb_rsp.ack;
        n++;
    end
    rdata = wb_rsp.dat_r;
    @(posedge pcie_clk);
    #1;
    wb_req = '0;
    if (!acked) begin
        $display("%s: the bus access at address %h was never acknowledged", name, adr);
        test_errors++;
    end
endtask

task automatic wait_idle(string name);
    int idle;
    int n;
    idle = 0;
    n = 0;
    while (idle < IDLE_CYCLES && n < DRAIN_TIMEOUT) begin
        @(negedge pcie_clk);
        if (!meta_out_valid && !meta_in_valid && pkt_q.size() == 0) begin
            idle++;
        end else begin
            idle = 0;
        end
        n++;
    end
    if (idle < IDLE_CYCLES) begin
        $display("%s: the output stream did not drain in time", name);
        test_errors++;
    end
endtask

task automatic compare_entries(string name);
    check_value(name, 32'(exp_q.size()), 32'(sb_q.size()));
    for (int i = 0; i < exp_q.size() && i < sb_q.size(); i++) begin
        assert (sb_q[i] == exp_q[i]) else begin
            $display("ERROR %s: entry %0d expected %h, actual %h", name, i, exp_q[i], sb_q[i]);
            test_errors++;
        end
    end
    exp_q.delete();
    sb_q.delete();
endtask

task automatic check_balance(string name, logic [31:0] writes);
    logic [31:0] ignored;
    logic [31:0] served;
    int          dsc_count;
    dsc_count = 0;
    wait_idle(name);
    bus_access(name, 1'b0, REG_IGNORED_HEAD_CNT, 4'hf, 32'h0, ignored);
    bus_access(name, 1'b0, REG_HEAD_UPD_CNT, 4'hf, 32'h0, served);
    foreach (sb_q[i]) begin
        if (sb_q[i].descriptor_only) begin
            dsc_count++;
        end
    end
    check_value(name, writes, ignored + served);
    check_value(name, served, 32'(dsc_count));
    sb_q.delete();
    exp_q.delete();
endtask

task automatic run_step(int i);
    logic [31:0] rdata;
    pkt_meta_t   pkt;
    queue_meta_t entry;
    int          n;
    case (op_q[i])
        OP_WRITE: bus_access(name_q[i], 1'b1, adr_q[i], sel_q[i], data_q[i], rdata);
        OP_READ: begin
            bus_access(name_q[i], 1'b0, adr_q[i], sel_q[i], 32'h0, rdata);
            check_value(name_q[i], data_q[i], rdata);
        end
        OP_PKT: begin
            if (data_q[i][31]) begin
                last_rand_size = 16'($random(seed));
            end
            pkt.pkt_queue_id = adr_q[i][3:0];
            pkt.size = data_q[i][31] ? last_rand_size : data_q[i][15:0];
            pkt_q.push_back(pkt);
        end
        OP_EXPECT: begin
            entry.pkt_queue_id = adr_q[i][3:0];
            entry.size = data_q[i][31] ? last_rand_size : data_q[i][15:0];
            entry.descriptor_only = data_q[i][17];
            entry.needs_dsc = data_q[i][16];
            exp_q.push_back(entry);
        end
        OP_HOLD: begin
            @(posedge pcie_clk);
            #1;
            meta_out_ready = 1'b0;
        end
        OP_RELEASE: begin
            @(posedge pcie_clk);
            #1;
            meta_out_ready = 1'b1;
        end
        OP_DRAIN: begin
            wait_idle(name_q[i]);
            compare_entries(name_q[i]);
        end
        OP_DISABLE: check_value(name_q[i], data_q[i], {31'h0, disable_pcie});
        OP_SETTLE: begin
            n = 0;
            while ((pkt_q.size() != 0 || meta_in_valid) && n < DRAIN_TIMEOUT) begin
                @(negedge pcie_clk);
                n++;
            end
            if (pkt_q.size() != 0 || meta_in_valid) begin
                $display("%s: the queued packets were not accepted in time", name_q[i]);
                test_errors++;
            end
        end
        OP_BALANCE: check_balance(name_q[i], data_q[i]);
        default: begin
            $display("%s: unknown step in the table", name_q[i]);
            test_errors++;
        end
    endcase
endtask

task automatic finish_test(string name);
    if (test_errors == 0) begin
        $display("test %s: ok", name);
        tests_passed++;
    end else begin
        $display("test %s: failed with %0d errors", name, test_errors);
        tests_failed++;
    end
    errors += test_errors;
    test_errors = 0;
endtask

initial begin
    string current;
    current = "";
    load_table();
    rows = name_q.size();
    repeat (2) @(posedge pcie_clk);
    #1;
    pcie_reset_n = 1'b1;
    for (int i = 0; i < rows; i++) begin
        if (current != "" && name_q[i] != current) begin
            finish_test(current);
        end
        current = name_q[i];
        run_step(i);
    end
    if (current != "") begin
        finish_test(current);
    end
    $display("%0d tests run, %0d passed, %0d failed, %0d errors",
             tests_passed + tests_failed, tests_passed, tests_failed, errors);
    if (errors == 0) begin
        $display("SIMULATION PASSED");
    end else begin
        $display("SIMULATION FAILED");
    end
    $finish;
end

// Each table row gets a fixed number of cycles
initial begin
    wait (rows > 0);
    #(rows * ROW_BOUND_CYCLES * CLK_PERIOD);
    $display("Watchdog expired before the table finished");
    $display("SIMULATION FAILED");
    $finish;
end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
rx_meta_pkg.sv
sync_fifo.sv
mmio_regs.sv
rx_stats_counters.sv
rx_meta_arbiter.sv
rx_meta_top.sv
tb_rx_meta_top.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST ?= vlog.f
TB_TOP ?= tb_rx_meta_top
RTL_TOP ?= rx_meta_top
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing
LINT_FLAGS ?= --lint-only --timing
PASS_TEXT ?= SIMULATION PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) | tee /dev/stderr | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(BUILD_DIR)
